// File: Bender.yml
package:
  name: qsnd

sources:
  - qsnd_cfg_pkg.sv
  - qsnd_reg_pkg.sv
  - qsnd_cmd_latch.sv
  - qsnd_voice.sv
  - qsnd_mixer.sv
  - qsnd_top.sv
  - target: test
    files:
      - qsnd_props.sv
      - tb_qsnd.sv

// File: qsnd_cfg_pkg.sv
package qsnd_cfg_pkg;

    // voices instantiated when the top level is left at its default
    localparam int NUM_VOICES_DEF = 4;

    // sample ROM space, max 8 MB
    localparam int ROM_AW = 23;

    // bank sits above the 16-bit phase integer part
    localparam int BANK_W = 7;

    // phase and step are fixed point, this many bits below the point
    localparam int PHASE_FRAC = 12;

    localparam int SAMPLE_W = 16; // left/right output width

endpackage

// File: qsnd_cmd_latch.sv
module qsnd_cmd_latch (
    input  logic        clk,
    input  logic        rst,
    input  logic [2:0]  host_addr,
    input  logic [7:0]  host_wdata,
    input  logic        host_we,
    input  logic        host_rd,
    output logic [7:0]  host_rdata,
    input  logic        frame_start,
    output logic [7:0]  cmd_addr,
    output logic [15:0] cmd_data,
    output logic        cmd_valid
);
    import qsnd_reg_pkg::*;

    logic [7:0] data_hi; // staging bytes, copied into the command on commit
    logic [7:0] data_lo;
    logic       cmd_pending;
    logic       addr_wr;
    logic       commit;

    assign addr_wr = host_we && (host_addr == OFS_ADDR);
    // an address write while busy is lost, firmware is expected to poll
    assign commit  = addr_wr && !cmd_pending;

    assign cmd_valid = cmd_pending;

    // data bytes and the committed command
    always_ff @(posedge clk) begin
        if (host_we && host_addr == OFS_DATA_HI) begin
            data_hi <= host_wdata;
        end
        if (host_we && host_addr == OFS_DATA_LO) begin
            data_lo <= host_wdata;
        end
        if (commit) begin
            cmd_addr <= host_wdata;
            cmd_data <= {data_hi, data_lo};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd_pending <= 1'b0;
        end else begin
            if (frame_start) begin
                cmd_pending <= 1'b0; // voices take it this cycle
            end
            if (commit) begin
                cmd_pending <= 1'b1;
            end
        end
    end

    // status read, one cycle after host_rd
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            host_rdata <= 8'h00;
        end else if (host_rd) begin
            if (host_addr == OFS_STATUS) begin
                host_rdata <= {cmd_pending, 7'b0};
            end else begin
                host_rdata <= 8'hff; // nothing else is readable
            end
        end
    end

endmodule

// File: qsnd_mixer.sv
module qsnd_mixer #(
    parameter int NUM_VOICES = qsnd_cfg_pkg::NUM_VOICES_DEF
) (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         sample_cen,
    input  logic [NUM_VOICES*qsnd_cfg_pkg::ROM_AW-1:0]   voice_addr,
    input  logic [NUM_VOICES*8-1:0]                      voice_vol,
    input  logic [NUM_VOICES*2-1:0]                      voice_pan,
    input  logic [NUM_VOICES-1:0]                        voice_active,
    output logic                                         frame_start,
    output logic [qsnd_cfg_pkg::ROM_AW-1:0]              qsnd_addr,
    output logic                                         qsnd_cs,
    input  logic [7:0]                                   qsnd_data,
    input  logic                                         qsnd_ok,
    output logic signed [qsnd_cfg_pkg::SAMPLE_W-1:0]     left,
    output logic signed [qsnd_cfg_pkg::SAMPLE_W-1:0]     right,
    output logic                                         sample
);
    import qsnd_cfg_pkg::*;
    import qsnd_reg_pkg::*;

    localparam int IDX_W = (NUM_VOICES > 1) ? $clog2(NUM_VOICES) : 1;
    localparam int ACC_W = 18; // headroom for four full-scale voices

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SYNC,  // frame_start high, voices step
        ST_VISIT,
        ST_FETCH
    } state_t;

    state_t                    state;
    logic [IDX_W-1:0]          idx;
    logic                      armed;
    logic [ROM_AW-1:0]         cur_addr;
    logic [7:0]                cur_vol;
    logic [1:0]                cur_pan;
    logic                      cur_active;
    logic                      take;
    logic                      done_voice;
    logic                      last;
    logic signed [15:0]        prod;
    logic signed [ACC_W-1:0]   prod_ext;
    logic signed [ACC_W-1:0]   acc_l;
    logic signed [ACC_W-1:0]   acc_r;
    logic signed [ACC_W-1:0]   acc_l_next;
    logic signed [ACC_W-1:0]   acc_r_next;

    function automatic logic signed [SAMPLE_W-1:0] sat(input logic signed [ACC_W-1:0] v);
        logic [ACC_W-SAMPLE_W:0] top;
        top = v[ACC_W-1:SAMPLE_W-1];
        if (&top || ~|top) begin
            sat = v[SAMPLE_W-1:0];
        end else if (v[ACC_W-1]) begin
            sat = {1'b1, {(SAMPLE_W-1){1'b0}}}; // clip negative
        end else begin
            sat = {1'b0, {(SAMPLE_W-1){1'b1}}};
        end
    endfunction

    assign cur_addr   = voice_addr[idx*ROM_AW +: ROM_AW];
    assign cur_vol    = voice_vol[idx*8 +: 8];
    assign cur_pan    = voice_pan[idx*2 +: 2];
    assign cur_active = voice_active[idx];

    assign take       = (state == ST_FETCH) && qsnd_ok;
    assign done_voice = ((state == ST_VISIT) && !cur_active) || take;
    assign last       = (idx == IDX_W'(NUM_VOICES - 1));

    // signed byte times unsigned volume always fits 16 bits
    assign prod     = $signed(qsnd_data) * $signed({1'b0, cur_vol});
    assign prod_ext = ACC_W'(prod);

    assign acc_l_next = acc_l + ((take && cur_pan[CTRL_PAN_L]) ? prod_ext : '0);
    assign acc_r_next = acc_r + ((take && cur_pan[CTRL_PAN_R]) ? prod_ext : '0);

    always_ff @(posedge clk) begin
        if (state == ST_SYNC) begin
            acc_l <= '0;
            acc_r <= '0;
        end else if (take) begin
            acc_l <= acc_l_next;
            acc_r <= acc_r_next;
        end
        if (state == ST_VISIT && cur_active) begin
            qsnd_addr <= cur_addr; // held until the fetch ends
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= ST_IDLE;
            idx         <= '0;
            armed       <= 1'b0;
            frame_start <= 1'b0;
            qsnd_cs     <= 1'b0;
            sample      <= 1'b0;
            left        <= '0;
            right       <= '0;
        end else begin
            frame_start <= 1'b0;
            sample      <= 1'b0;
            case (state)
                ST_IDLE: if (sample_cen) begin
                    frame_start <= 1'b1;
                    state       <= ST_SYNC;
                end
                ST_SYNC: begin
                    idx   <= '0;
                    state <= ST_VISIT;
                end
                ST_VISIT: if (cur_active) begin
                    qsnd_cs <= 1'b1;
                    armed   <= 1'b1; // strobes start once a voice has played
                    state   <= ST_FETCH;
                end
                ST_FETCH: if (qsnd_ok) qsnd_cs <= 1'b0;
                default: state <= ST_IDLE;
            endcase
            if (done_voice) begin
                if (last) begin
                    state <= ST_IDLE;
                    if (armed) begin
                        left   <= sat(acc_l_next);
                        right  <= sat(acc_r_next);
                        sample <= 1'b1;
                    end
                end else begin
                    idx   <= idx + 1'b1;
                    state <= ST_VISIT;
                end
            end
        end
    end

endmodule

// File: qsnd_props.sv
module qsnd_props #(
    parameter int N = 4
) (
    input logic                            clk,
    input logic                            rst,
    input logic                            sample,
    input logic                            qsnd_cs,
    input logic                            qsnd_ok,
    input logic [qsnd_cfg_pkg::ROM_AW-1:0] qsnd_addr,
    input logic [N-1:0]                    voice_active
);
    timeunit 1ns;
    timeprecision 1ps;

    int   err_count = 0; // watched by the testbench
    logic keyed;
    logic played;

    // set once any voice has been keyed on
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            keyed <= 1'b0;
        end else if (|voice_active) begin
            keyed <= 1'b1;
        end
    end

    assign played = keyed || (|voice_active);

    a_strobe_single: assert property (@(posedge clk) disable iff (rst)
        sample |=> !sample)
        else begin
            $error("sample high two cycles running");
            err_count++;
        end

    a_addr_stable: assert property (@(posedge clk) disable iff (rst)
        qsnd_cs && !qsnd_ok |=> $stable(qsnd_addr))
        else begin
            $error("qsnd_addr moved during a fetch");
            err_count++;
        end

    a_strobe_vs_fetch: assert property (@(posedge clk) disable iff (rst)
        !(sample && qsnd_cs))
        else begin
            $error("sample and qsnd_cs high together");
            err_count++;
        end

    a_quiet_until_key: assert property (@(posedge clk) disable iff (rst)
        !played |-> !sample && !qsnd_cs)
        else begin
            $error("activity before any key-on");
            err_count++;
        end

endmodule

// File: qsnd_reg_pkg.sv
package qsnd_reg_pkg;

    // host byte offsets
    localparam logic [2:0] OFS_DATA_HI = 3'd0; // data word MSB
    localparam logic [2:0] OFS_DATA_LO = 3'd1; // data word LSB
    localparam logic [2:0] OFS_ADDR    = 3'd2; // register address, commits the command
    localparam logic [2:0] OFS_STATUS  = 3'd7; // busy in bit 7

    // per-voice register index, low 3 bits of the command address byte
    // the voice number lives in the bits above
    localparam logic [2:0] REG_BANK  = 3'd0;
    localparam logic [2:0] REG_START = 3'd1;
    localparam logic [2:0] REG_END   = 3'd2;
    localparam logic [2:0] REG_LOOP  = 3'd3;
    localparam logic [2:0] REG_STEP  = 3'd4; // 4.12 pitch step
    localparam logic [2:0] REG_VOL   = 3'd5; // unsigned, low byte used
    localparam logic [2:0] REG_CTRL  = 3'd6;

    // REG_CTRL data word bits
    localparam int CTRL_KEY_BIT = 7; // 1 key-on, 0 key-off
    localparam int CTRL_PAN_L   = 0;
    localparam int CTRL_PAN_R   = 1;

endpackage

// File: qsnd_top.sv
module qsnd_top #(
    parameter int NUM_VOICES = qsnd_cfg_pkg::NUM_VOICES_DEF
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     sample_cen,
    input  logic [2:0]                               host_addr,
    input  logic [7:0]                               host_wdata,
    input  logic                                     host_we,
    input  logic                                     host_rd,
    output logic [7:0]                               host_rdata,
    output logic [qsnd_cfg_pkg::ROM_AW-1:0]          qsnd_addr,
    output logic                                     qsnd_cs,
    input  logic [7:0]                               qsnd_data,
    input  logic                                     qsnd_ok,
    output logic signed [qsnd_cfg_pkg::SAMPLE_W-1:0] left,
    output logic signed [qsnd_cfg_pkg::SAMPLE_W-1:0] right,
    output logic                                     sample
);
    import qsnd_cfg_pkg::*;

    logic [7:0]                   cmd_addr;
    logic [15:0]                  cmd_data;
    logic                         cmd_valid;
    logic                         frame_start;
    logic [NUM_VOICES*ROM_AW-1:0] voice_addr;
    logic [NUM_VOICES*8-1:0]      voice_vol;
    logic [NUM_VOICES*2-1:0]      voice_pan;
    logic [NUM_VOICES-1:0]        voice_active;

    qsnd_cmd_latch u_latch (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .host_addr   ( host_addr   ),
        .host_wdata  ( host_wdata  ),
        .host_we     ( host_we     ),
        .host_rd     ( host_rd     ),
        .host_rdata  ( host_rdata  ),
        .frame_start ( frame_start ),
        .cmd_addr    ( cmd_addr    ),
        .cmd_data    ( cmd_data    ),
        .cmd_valid   ( cmd_valid   )
    );

    // every voice sees the same command, only the addressed one takes it
    for (genvar v = 0; v < NUM_VOICES; v++) begin : g_voice
        qsnd_voice #(.VOICE_ID(v)) u_voice (
            .clk         ( clk                              ),
            .rst         ( rst                              ),
            .frame_start ( frame_start                      ),
            .cmd_addr    ( cmd_addr                         ),
            .cmd_data    ( cmd_data                         ),
            .cmd_valid   ( cmd_valid                        ),
            .rom_addr    ( voice_addr[v*ROM_AW +: ROM_AW]   ),
            .vol         ( voice_vol[v*8 +: 8]              ),
            .pan         ( voice_pan[v*2 +: 2]              ),
            .active      ( voice_active[v]                  )
        );
    end

    qsnd_mixer #(.NUM_VOICES(NUM_VOICES)) u_mixer (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .sample_cen   ( sample_cen   ),
        .voice_addr   ( voice_addr   ),
        .voice_vol    ( voice_vol    ),
        .voice_pan    ( voice_pan    ),
        .voice_active ( voice_active ),
        .frame_start  ( frame_start  ),
        .qsnd_addr    ( qsnd_addr    ),
        .qsnd_cs      ( qsnd_cs      ),
        .qsnd_data    ( qsnd_data    ),
        .qsnd_ok      ( qsnd_ok      ),
        .left         ( left         ),
        .right        ( right        ),
        .sample       ( sample       )
    );

endmodule

// File: qsnd_voice.sv
module qsnd_voice #(
    parameter int VOICE_ID = 0
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            frame_start,
    input  logic [7:0]                      cmd_addr,
    input  logic [15:0]                     cmd_data,
    input  logic                            cmd_valid,
    output logic [qsnd_cfg_pkg::ROM_AW-1:0] rom_addr,
    output logic [7:0]                      vol,
    output logic [1:0]                      pan,
    output logic                            active
);
    import qsnd_cfg_pkg::*;
    import qsnd_reg_pkg::*;

    localparam int PHASE_INT = ROM_AW - BANK_W; // integer part, 16 bits
    localparam int PH_W      = PHASE_INT + PHASE_FRAC;

    logic [BANK_W-1:0]    bank_q;
    logic [PHASE_INT-1:0] start_q;
    logic [PHASE_INT-1:0] end_q;
    logic [PHASE_INT-1:0] loop_q;
    logic [15:0]          step_q;
    logic [PH_W-1:0]      phase;
    logic [PH_W-1:0]      phase_adv;
    logic [2:0]           cmd_reg;
    logic                 hit;
    logic                 key_on;
    logic                 key_off;
    logic                 wrap;

    assign cmd_reg = cmd_addr[2:0];
    assign hit     = frame_start && cmd_valid && (cmd_addr[7:3] == 5'(VOICE_ID));
    assign key_on  = hit && (cmd_reg == REG_CTRL) && cmd_data[CTRL_KEY_BIT];
    assign key_off = hit && (cmd_reg == REG_CTRL) && !cmd_data[CTRL_KEY_BIT];

    assign phase_adv = phase + PH_W'(step_q);
    assign wrap      = phase_adv[PHASE_FRAC +: PHASE_INT] >= end_q; // end reached

    assign rom_addr = {bank_q, phase[PHASE_FRAC +: PHASE_INT]};

    always_ff @(posedge clk) begin
        if (hit) begin
            case (cmd_reg)
                REG_BANK:  bank_q  <= cmd_data[BANK_W-1:0];
                REG_START: start_q <= PHASE_INT'(cmd_data);
                REG_END:   end_q   <= PHASE_INT'(cmd_data);
                REG_LOOP:  loop_q  <= PHASE_INT'(cmd_data);
                REG_STEP:  step_q  <= cmd_data;
                REG_VOL:   vol     <= cmd_data[7:0];
                default: ;
            endcase
        end
        if (key_on) begin
            phase <= {start_q, {PHASE_FRAC{1'b0}}}; // no advance on key-on
        end else if (frame_start && active) begin
            if (wrap && loop_q != '0) begin
                phase <= phase_adv - {loop_q, {PHASE_FRAC{1'b0}}};
            end else begin
                phase <= phase_adv;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active <= 1'b0;
            pan    <= 2'b00;
        end else begin
            if (key_on) begin
                active <= 1'b1;
            end else if (key_off) begin
                active <= 1'b0;
            end else if (frame_start && active && wrap && loop_q == '0) begin
                active <= 1'b0; // one-shot sample ran out
            end
            if (hit && cmd_reg == REG_CTRL) begin
                pan[CTRL_PAN_L] <= cmd_data[CTRL_PAN_L];
                pan[CTRL_PAN_R] <= cmd_data[CTRL_PAN_R];
            end
        end
    end

endmodule

// File: tb.f
qsnd_cfg_pkg.sv
qsnd_reg_pkg.sv
qsnd_cmd_latch.sv
qsnd_voice.sv
qsnd_mixer.sv
qsnd_top.sv
qsnd_props.sv
tb_qsnd.sv

// File: tb_qsnd.sv
module tb_qsnd;
    timeunit 1ns;
    timeprecision 1ps;
    import qsnd_cfg_pkg::*;
    import qsnd_reg_pkg::*;

    localparam int NV          = 4;
    localparam int CEN_PERIOD  = 64;
    localparam int NUM_FRAMES  = 62; // setup, reset, busy, pitch, mix, saturation, end/loop
    localparam int CYCLE_LIMIT = (NUM_FRAMES + 4) * CEN_PERIOD;

    logic                       clk;
    logic                       rst;
    logic                       sample_cen;
    logic [2:0]                 host_addr;
    logic [7:0]                 host_wdata;
    logic                       host_we;
    logic                       host_rd;
    logic [7:0]                 host_rdata;
    logic [ROM_AW-1:0]          qsnd_addr;
    logic                       qsnd_cs;
    logic [7:0]                 qsnd_data;
    logic                       qsnd_ok;
    logic signed [SAMPLE_W-1:0] left;
    logic signed [SAMPLE_W-1:0] right;
    logic                       sample;

    logic [31:0] lfsr = 32'h6e153cad;
    int          cen_cnt = 0;
    int          cycles = 0;
    int          wait_left = 0;
    bit          fetching = 0;

    // expected voice state, kept from the register and end/loop rules
    logic [BANK_W-1:0] m_bank[NV];
    logic [15:0]       m_start[NV];
    logic [15:0]       m_end[NV];
    logic [15:0]       m_loop[NV];
    logic [15:0]       m_step[NV];
    logic [7:0]        m_vol[NV];
    logic [1:0]        m_pan[NV];
    logic [27:0]       m_phase[NV];
    bit                m_act[NV];
    logic [ROM_AW-1:0] exp_addr[$];
    logic [ROM_AW-1:0] fetched[$];
    int                exp_l;
    int                exp_r;

    qsnd_top #(.NUM_VOICES(NV)) qsnd_top_inst (.*);

    bind qsnd_top qsnd_props #(.N(NUM_VOICES)) props_inst (
        .clk(clk), .rst(rst), .sample(sample), .qsnd_cs(qsnd_cs),
        .qsnd_ok(qsnd_ok), .qsnd_addr(qsnd_addr), .voice_active(voice_active)
    );

    always #10 clk = ~clk;

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int exp, input logic signed [31:0] act);
        assert (act === exp) else report_fail($sformatf("Fail %s expected %0d actual %0d",
            name, exp, act));
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [7:0] cmd_address(input int v, input logic [2:0] r);
        return {v[4:0], r};
    endfunction

    function automatic int clamp16(input int x);
        return (x > 32767) ? 32767 : ((x < -32768) ? -32768 : x);
    endfunction

    always @(negedge clk) begin
        sample_cen = (cen_cnt == CEN_PERIOD - 1);
        cen_cnt    = (cen_cnt == CEN_PERIOD - 1) ? 0 : cen_cnt + 1;
    end

    // sample ROM, 0 to 3 wait cycles per fetch
    always @(negedge clk) begin
        qsnd_data = qsnd_addr[7:0] ^ 8'h5a;
        if (!qsnd_cs) begin
            qsnd_ok  = 1'b0;
            fetching = 0;
        end else if (!fetching) begin
            fetching  = 1;
            wait_left = lfsr[0];
            lfsr      = lfsr_next(lfsr);
            wait_left = 2 * wait_left + lfsr[0];
            lfsr      = lfsr_next(lfsr); // two bits taken
            qsnd_ok   = (wait_left == 0);
        end else if (!qsnd_ok) begin
            wait_left--;
            qsnd_ok = (wait_left == 0);
        end
    end

    always @(posedge clk) begin
        if (qsnd_cs && qsnd_ok) fetched.push_back(qsnd_addr);
        cycles++;
        if (cycles >= CYCLE_LIMIT)
            report_fail($sformatf("timeout, run still going after %0d cycles", cycles));
    end

    always @(qsnd_top_inst.props_inst.err_count) begin
        if (qsnd_top_inst.props_inst.err_count != 0)
            report_fail("a concurrent assertion on the DUT ports failed");
    end

    task automatic host_write(input logic [2:0] a, input logic [7:0] d);
        @(negedge clk);
        host_addr  = a;
        host_wdata = d;
        host_we    = 1'b1;
        @(negedge clk);
        host_we = 1'b0;
    endtask

    task automatic host_read(input logic [2:0] a, output logic [7:0] d);
        @(negedge clk);
        host_addr = a;
        host_rd   = 1'b1;
        @(negedge clk);
        host_rd = 1'b0;
        d       = host_rdata; // registered, valid now
    endtask

    task automatic send_cmd(input logic [7:0] a, input logic [15:0] d);
        logic [7:0] s;
        host_write(OFS_DATA_HI, d[15:8]);
        host_write(OFS_DATA_LO, d[7:0]);
        do host_read(OFS_STATUS, s); while (s[7]); // wait until not busy
        host_write(OFS_ADDR, a);
    endtask

    task automatic apply_cmd(input logic [7:0] a, input logic [15:0] d);
        int v;
        v = a[7:3];
        if (v < NV) begin
            case (a[2:0])
                REG_BANK:  m_bank[v]  = d[BANK_W-1:0];
                REG_START: m_start[v] = d;
                REG_END:   m_end[v]   = d;
                REG_LOOP:  m_loop[v]  = d;
                REG_STEP:  m_step[v]  = d;
                REG_VOL:   m_vol[v]   = d[7:0];
                REG_CTRL: begin
                    m_pan[v] = {d[CTRL_PAN_R], d[CTRL_PAN_L]};
                    m_act[v] = d[CTRL_KEY_BIT];
                    if (d[CTRL_KEY_BIT]) m_phase[v] = {m_start[v], 12'h000};
                end
                default: ;
            endcase
        end
    endtask

    // one frame, advance with old registers, then the command, then the mix
    task automatic model_frame(input bit has_cmd, input logic [7:0] a, input logic [15:0] d);
        logic [27:0]       adv;
        logic [ROM_AW-1:0] addr;
        logic signed [7:0] b;
        int                sl;
        int                sr;
        for (int v = 0; v < NV; v++) begin
            if (m_act[v]) begin
                adv = m_phase[v] + 28'(m_step[v]);
                if (adv[27:12] >= m_end[v]) begin
                    if (m_loop[v] != 0) adv = adv - {m_loop[v], 12'h000};
                    else m_act[v] = 0; // one-shot ends
                end
                m_phase[v] = adv;
            end
        end
        if (has_cmd) apply_cmd(a, d);
        exp_addr.delete();
        sl = 0;
        sr = 0;
        for (int v = 0; v < NV; v++) begin
            if (m_act[v]) begin
                addr = {m_bank[v], m_phase[v][27:12]};
                exp_addr.push_back(addr);
                b = addr[7:0] ^ 8'h5a;
                if (m_pan[v][CTRL_PAN_L]) sl += b * int'(m_vol[v]);
                if (m_pan[v][CTRL_PAN_R]) sr += b * int'(m_vol[v]);
            end
        end
        exp_l = clamp16(sl);
        exp_r = clamp16(sr);
    endtask

    task automatic wait_sample();
        do @(negedge clk); while (!sample);
    endtask

    task automatic check_frame(input string name);
        check_value({name, " fetch count"}, exp_addr.size(), fetched.size());
        foreach (exp_addr[i]) check_value({name, " rom addr"}, exp_addr[i], fetched[i]);
        check_value({name, " left"}, exp_l, left);
        check_value({name, " right"}, exp_r, right);
    endtask

    task automatic run_frame(input string name, input bit has_cmd, input int v = 0,
                             input logic [2:0] r = 3'd0, input logic [15:0] d = 16'h0);
        fetched.delete();
        if (has_cmd) send_cmd(cmd_address(v, r), d);
        model_frame(has_cmd, cmd_address(v, r), d);
        wait_sample();
        check_frame(name);
    endtask

    task automatic setup_reg(input int v, input logic [2:0] r, input logic [15:0] d);
        send_cmd(cmd_address(v, r), d);
        apply_cmd(cmd_address(v, r), d); // nothing plays yet
    endtask

    initial begin
        logic [7:0] rd;
        clk        = 1'b0;
        rst        = 1'b1;
        sample_cen = 1'b0;
        host_addr  = 3'd0;
        host_wdata = 8'h00;
        host_we    = 1'b0;
        host_rd    = 1'b0;
        qsnd_data  = 8'h00;
        qsnd_ok    = 1'b0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        check_value("reset left", 0, left);
        check_value("reset right", 0, right);
        host_read(OFS_STATUS, rd);
        check_value("reset status", 0, rd);
        host_read(OFS_DATA_HI, rd);
        check_value("other offset", 8'hff, rd);
        setup_reg(0, REG_BANK, 16'h0012);
        setup_reg(0, REG_START, 16'h0100);
        setup_reg(0, REG_END, 16'h0110);
        setup_reg(0, REG_LOOP, 16'h0008);
        setup_reg(0, REG_STEP, 16'h1000);
        setup_reg(0, REG_VOL, 16'h0000);
        run_frame("reset zero", 1, 0, REG_CTRL, 16'h0083);
        run_frame("reset zero", 0);

        // busy bit, second address write dropped
        fetched.delete();
        send_cmd(cmd_address(0, REG_VOL), 16'h0040);
        host_read(OFS_STATUS, rd);
        check_value("busy set", 8'h80, rd);
        host_write(OFS_DATA_HI, 8'h00);
        host_write(OFS_DATA_LO, 8'h7f);
        host_write(OFS_ADDR, cmd_address(0, REG_VOL));
        model_frame(1, cmd_address(0, REG_VOL), 16'h0040);
        wait_sample();
        check_frame("busy drop");
        host_read(OFS_STATUS, rd);
        check_value("busy clear", 0, rd);

        repeat (4) run_frame("pitch", 0);
        run_frame("pitch", 1, 0, REG_STEP, 16'h0800);
        repeat (4) run_frame("pitch half", 0);

        run_frame("mix", 1, 1, REG_BANK, 16'h0005);
        run_frame("mix", 1, 1, REG_START, 16'h0025);
        run_frame("mix", 1, 1, REG_END, 16'h4000);
        run_frame("mix", 1, 1, REG_LOOP, 16'h0000);
        run_frame("mix", 1, 1, REG_STEP, 16'h0000);
        run_frame("mix", 1, 1, REG_VOL, 16'h0090);
        run_frame("mix", 1, 1, REG_CTRL, 16'h0082);
        run_frame("mix", 1, 0, REG_VOL, 16'h0070);
        run_frame("mix", 1, 0, REG_CTRL, 16'h0081);
        repeat (2) run_frame("mix", 0);

        run_frame("saturate", 1, 0, REG_STEP, 16'h0000);
        run_frame("saturate", 1, 0, REG_VOL, 16'h00ff);
        run_frame("saturate", 1, 1, REG_VOL, 16'h00ff);
        run_frame("saturate", 1, 0, REG_START, 16'h0025);
        run_frame("saturate", 1, 0, REG_CTRL, 16'h0083);
        run_frame("saturate", 1, 1, REG_CTRL, 16'h0083);
        run_frame("saturate", 0);
        run_frame("saturate neg", 1, 0, REG_START, 16'h00da);
        run_frame("saturate neg", 1, 1, REG_START, 16'h00da);
        run_frame("saturate neg", 1, 0, REG_CTRL, 16'h0083);
        run_frame("saturate neg", 1, 1, REG_CTRL, 16'h0083);
        run_frame("saturate neg", 0);

        run_frame("end loop", 1, 1, REG_CTRL, 16'h0000);
        run_frame("end loop", 1, 0, REG_START, 16'h0200);
        run_frame("end loop", 1, 0, REG_END, 16'h0204);
        run_frame("end loop", 1, 0, REG_LOOP, 16'h0003);
        run_frame("end loop", 1, 0, REG_STEP, 16'h1000);
        run_frame("end loop", 1, 0, REG_VOL, 16'h0040);
        run_frame("end loop", 1, 0, REG_CTRL, 16'h0081);
        repeat (6) run_frame("end loop", 0);
        run_frame("one shot", 1, 0, REG_LOOP, 16'h0000);
        repeat (5) run_frame("one shot", 0);

        if (qsnd_top_inst.props_inst.err_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Finished with errors");
            $fatal(1);
        end
    end

endmodule
